// ==== fp_mult.f ====
hw/fp_mult_pkg.sv
hw/fp_mult_if.sv
hw/fp_unpack.sv
hw/fp_mant_mult.sv
hw/fp_round_pack.sv
hw/fp_mult.sv
verification/fp_mult_sva.sv
verification/fp_mult_tb.sv

// ==== hw/fp_mant_mult.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_mant_mult #(
	parameter int MULT_STAGES = fp_mult_pkg::DEFAULT_MULT_STAGES
) (
	input  wire logic  clk,
	input  wire logic  rst,
	fp_operand_if.dst  in,
	fp_product_if.src  out
);

	if (MULT_STAGES < 1 || MULT_STAGES > 4) begin : g_bad_depth
		$error("fp_mant_mult: MULT_STAGES must be between 1 and 4");
	end

	fp_mult_pkg::prod_t  prod_comb;

	// one entry per register in the chain, index 0 is nearest the input
	logic [MULT_STAGES-1:0]  vld_q;
	logic                    sign_q    [MULT_STAGES];
	fp_mult_pkg::exp_t       exp_q     [MULT_STAGES];
	fp_mult_pkg::prod_t      prod_q    [MULT_STAGES];
	logic                    spec_q    [MULT_STAGES];
	fp_mult_pkg::word_t      spec_z_q  [MULT_STAGES];

	// plain product, synthesis is free to retime it into the chain
	assign prod_comb = in.mant_a * in.mant_b;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vld_q <= '0;
		end else begin
			vld_q[0] <= in.valid;
			for (int i = 1; i < MULT_STAGES; i++)
				vld_q[i] <= vld_q[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (in.valid) begin
			sign_q[0]   <= in.sign;
			exp_q[0]    <= in.exp_sum;
			prod_q[0]   <= prod_comb;
			spec_q[0]   <= in.special;
			spec_z_q[0] <= in.special_z;
		end
		for (int i = 1; i < MULT_STAGES; i++) begin
			if (vld_q[i-1]) begin
				sign_q[i]   <= sign_q[i-1];
				exp_q[i]    <= exp_q[i-1];
				prod_q[i]   <= prod_q[i-1];
				spec_q[i]   <= spec_q[i-1];
				spec_z_q[i] <= spec_z_q[i-1];
			end
		end
	end

	assign out.valid     = vld_q[MULT_STAGES-1];
	assign out.sign      = sign_q[MULT_STAGES-1];
	assign out.exp_sum   = exp_q[MULT_STAGES-1];
	assign out.product   = prod_q[MULT_STAGES-1];
	assign out.special   = spec_q[MULT_STAGES-1];
	assign out.special_z = spec_z_q[MULT_STAGES-1];

endmodule

`default_nettype wire

// ==== hw/fp_mult.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_mult #(
	parameter int MULT_STAGES = fp_mult_pkg::DEFAULT_MULT_STAGES
) (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire fp_mult_pkg::word_t  a,
	input  wire fp_mult_pkg::word_t  b,
	input  wire logic                in_valid,
	output fp_mult_pkg::word_t       z,
	output logic                     valid_out
);

	fp_operand_if operand_bus ();
	fp_product_if product_bus ();

	// classify and register the operand pair
	fp_unpack unpack_inst (
		.clk      (clk),
		.rst      (rst),
		.a        (a),
		.b        (b),
		.in_valid (in_valid),
		.out      (operand_bus.src)
	);

	// MULT_STAGES deep product pipeline
	fp_mant_mult #(
		.MULT_STAGES (MULT_STAGES)
	) mant_mult_inst (
		.clk (clk),
		.rst (rst),
		.in  (operand_bus.dst),
		.out (product_bus.src)
	);

	fp_round_pack round_pack_inst (
		.clk       (clk),
		.rst       (rst),
		.in        (product_bus.dst),
		.z         (z),
		.valid_out (valid_out)
	);

endmodule

`default_nettype wire

// ==== hw/fp_mult_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// unpacked operands, unpack stage to mantissa multiplier
interface fp_operand_if;
	logic                valid;
	logic                sign;
	fp_mult_pkg::exp_t   exp_sum;
	fp_mult_pkg::mant_t  mant_a;
	fp_mult_pkg::mant_t  mant_b;
	logic                special;
	fp_mult_pkg::word_t  special_z;

	modport src (output valid, sign, exp_sum, mant_a, mant_b, special, special_z);
	modport dst (input valid, sign, exp_sum, mant_a, mant_b, special, special_z);
endinterface

// raw product, mantissa multiplier to round and pack
interface fp_product_if;
	logic                valid;
	logic                sign;
	fp_mult_pkg::exp_t   exp_sum;
	fp_mult_pkg::prod_t  product;
	logic                special;
	fp_mult_pkg::word_t  special_z;

	modport src (output valid, sign, exp_sum, product, special, special_z);
	modport dst (input valid, sign, exp_sum, product, special, special_z);
endinterface

`default_nettype wire

// ==== hw/fp_mult_pkg.sv ====
`default_nettype none

package fp_mult_pkg;

	// ieee-754 double field widths
	localparam int EXP_W  = 11;
	localparam int FRAC_W = 52;
	localparam int MANT_W = FRAC_W + 1;

	localparam int BIAS    = 1023;
	localparam int EXP_INF = 2047;

	// one full double word, sign at the top
	typedef logic [EXP_W+FRAC_W:0] word_t;

	typedef logic [FRAC_W-1:0] frac_t;

	// fraction with the hidden bit in front
	typedef logic [MANT_W-1:0] mant_t;

	// biased exponent with two bits of headroom so that
	// overflow and underflow can be seen before packing
	typedef logic signed [EXP_W+1:0] exp_t;

	typedef logic [2*MANT_W-1:0] prod_t;

	// quiet nan returned for every invalid operation
	localparam word_t QNAN = {
		1'b1,
		{EXP_W{1'b1}},
		1'b1,
		{(FRAC_W-1){1'b0}}
	};

	// depth of the mantissa multiplier register chain
	localparam int DEFAULT_MULT_STAGES = 2;

	// unpack register plus output register
	localparam int FIXED_STAGES = 2;

endpackage

`default_nettype wire

// ==== hw/fp_round_pack.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_round_pack (
	input  wire logic            clk,
	input  wire logic            rst,
	fp_product_if.dst            in,
	output fp_mult_pkg::word_t   z,
	output logic                 valid_out
);

	// product msb, set when the mantissa product is 2.0 or more
	localparam int TOP = 2 * fp_mult_pkg::MANT_W - 1;

	localparam logic [fp_mult_pkg::EXP_W-1:0] EXP_ONES =
		(fp_mult_pkg::EXP_W)'(fp_mult_pkg::EXP_INF);

	fp_mult_pkg::prod_t              prod_n;
	fp_mult_pkg::mant_t              mant;
	logic                            guard;
	logic                            rnd;
	logic                            sticky;
	logic                            round_up;
	logic [fp_mult_pkg::MANT_W:0]    mant_rnd;
	fp_mult_pkg::exp_t               exp_norm;
	fp_mult_pkg::exp_t               exp_final;
	logic                            overflow;
	logic                            flush;
	fp_mult_pkg::word_t              z_next;

	// one-bit normalize, the leading one always ends up at TOP
	always_comb begin
		if (in.product[TOP]) begin
			prod_n   = in.product;
			exp_norm = in.exp_sum + fp_mult_pkg::exp_t'(1);
		end else begin
			prod_n   = in.product << 1;
			exp_norm = in.exp_sum;
		end
	end

	assign mant   = prod_n[TOP -: fp_mult_pkg::MANT_W];
	assign guard  = prod_n[TOP - fp_mult_pkg::MANT_W];
	assign rnd    = prod_n[TOP - fp_mult_pkg::MANT_W - 1];
	assign sticky = |prod_n[TOP - fp_mult_pkg::MANT_W - 2:0];

	// nearest even: ties go up only when the lsb is odd
	assign round_up = guard & (rnd | sticky | mant[0]);

	assign mant_rnd = {1'b0, mant} + (fp_mult_pkg::MANT_W + 1)'(round_up);

	// carry out of the mantissa leaves 1.000..., so only the exponent moves
	assign exp_final = exp_norm
		+ fp_mult_pkg::exp_t'({1'b0, mant_rnd[fp_mult_pkg::MANT_W]});

	assign flush    = (exp_norm <= fp_mult_pkg::exp_t'(0));
	assign overflow = (exp_final >= fp_mult_pkg::exp_t'(fp_mult_pkg::EXP_INF));

	always_comb begin
		if (in.special) begin
			z_next = in.special_z;
		end else if (flush) begin
			z_next = {in.sign, {(fp_mult_pkg::EXP_W + fp_mult_pkg::FRAC_W){1'b0}}};
		end else if (overflow) begin
			z_next = {in.sign, EXP_ONES, {fp_mult_pkg::FRAC_W{1'b0}}};
		end else begin
			z_next = {
				in.sign,
				exp_final[fp_mult_pkg::EXP_W-1:0],
				mant_rnd[fp_mult_pkg::FRAC_W-1:0]
			};
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			valid_out <= 1'b0;
		else
			valid_out <= in.valid;
	end

	// z holds its value between results
	always_ff @(posedge clk) begin
		if (in.valid)
			z <= z_next;
	end

endmodule

`default_nettype wire

// ==== hw/fp_unpack.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_unpack (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire fp_mult_pkg::word_t  a,
	input  wire fp_mult_pkg::word_t  b,
	input  wire logic                in_valid,
	fp_operand_if.src                out
);

	localparam int SIGN_BIT = fp_mult_pkg::EXP_W + fp_mult_pkg::FRAC_W;

	localparam logic [fp_mult_pkg::EXP_W-1:0] EXP_ONES =
		(fp_mult_pkg::EXP_W)'(fp_mult_pkg::EXP_INF);

	logic [fp_mult_pkg::EXP_W-1:0] exp_a;
	logic [fp_mult_pkg::EXP_W-1:0] exp_b;
	fp_mult_pkg::frac_t            frac_a;
	fp_mult_pkg::frac_t            frac_b;
	logic                          nan_a, nan_b;
	logic                          inf_a, inf_b;
	logic                          zero_a, zero_b;
	logic                          sign_z;
	logic                          special;
	fp_mult_pkg::word_t            special_z;
	fp_mult_pkg::exp_t             exp_sum;

	assign exp_a  = a[SIGN_BIT-1:fp_mult_pkg::FRAC_W];
	assign exp_b  = b[SIGN_BIT-1:fp_mult_pkg::FRAC_W];
	assign frac_a = a[fp_mult_pkg::FRAC_W-1:0];
	assign frac_b = b[fp_mult_pkg::FRAC_W-1:0];
	assign sign_z = a[SIGN_BIT] ^ b[SIGN_BIT];

	assign nan_a  = (exp_a == EXP_ONES) && (frac_a != '0);
	assign nan_b  = (exp_b == EXP_ONES) && (frac_b != '0);
	assign inf_a  = (exp_a == EXP_ONES) && (frac_a == '0);
	assign inf_b  = (exp_b == EXP_ONES) && (frac_b == '0);
	// subnormals are flushed, so only the exponent field matters here
	assign zero_a = (exp_a == '0);
	assign zero_b = (exp_b == '0);

	// result exponent before normalization, still biased once
	assign exp_sum = fp_mult_pkg::exp_t'({2'b00, exp_a})
		+ fp_mult_pkg::exp_t'({2'b00, exp_b})
		- fp_mult_pkg::exp_t'(fp_mult_pkg::BIAS);

	// first match wins
	always_comb begin
		special   = 1'b1;
		special_z = '0;
		if (nan_a || nan_b) begin
			special_z = fp_mult_pkg::QNAN;
		end else if ((inf_a && zero_b) || (zero_a && inf_b)) begin
			special_z = fp_mult_pkg::QNAN;
		end else if (inf_a || inf_b) begin
			special_z = {sign_z, EXP_ONES, {fp_mult_pkg::FRAC_W{1'b0}}};
		end else if (zero_a || zero_b) begin
			special_z = {sign_z, {(fp_mult_pkg::EXP_W + fp_mult_pkg::FRAC_W){1'b0}}};
		end else begin
			special = 1'b0;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			out.valid <= 1'b0;
		else
			out.valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			out.sign      <= sign_z;
			out.exp_sum   <= exp_sum;
			out.mant_a    <= {1'b1, frac_a};
			out.mant_b    <= {1'b1, frac_b};
			out.special   <= special;
			out.special_z <= special_z;
		end
	end

endmodule

`default_nettype wire

// ==== verification/fp_mult_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_mult_sva #(
	parameter int MULT_STAGES = fp_mult_pkg::DEFAULT_MULT_STAGES
) (
	input wire logic                clk,
	input wire logic                rst,
	input wire fp_mult_pkg::word_t  a,
	input wire fp_mult_pkg::word_t  b,
	input wire logic                in_valid,
	input wire fp_mult_pkg::word_t  z,
	input wire logic                valid_out
);

	localparam int LATENCY = fp_mult_pkg::FIXED_STAGES + MULT_STAGES;

	int unsigned fail_count = 0;

	logic nan_in;
	logic invalid_in;
	logic inf_in;
	logic zero_in;
	logic sign_in;

	function automatic logic is_nan(input fp_mult_pkg::word_t w);
		return (w[62:52] == 11'h7ff) && (w[51:0] != '0);
	endfunction

	function automatic logic is_inf(input fp_mult_pkg::word_t w);
		return (w[62:52] == 11'h7ff) && (w[51:0] == '0);
	endfunction

	// subnormals count as zero
	function automatic logic is_zero(input fp_mult_pkg::word_t w);
		return w[62:52] == 11'h000;
	endfunction

	assign nan_in     = is_nan(a) || is_nan(b);
	assign invalid_in = nan_in || (is_inf(a) && is_zero(b)) || (is_zero(a) && is_inf(b));
	assign inf_in     = !invalid_in && (is_inf(a) || is_inf(b));
	assign zero_in    = !invalid_in && !inf_in && (is_zero(a) || is_zero(b));
	assign sign_in    = a[63] ^ b[63];

	// every valid bit in the pipeline must have been cleared by reset
	a_reset_quiet: assert property (@(posedge clk)
		$fell(rst) |-> !valid_out [*LATENCY])
		else begin
			$error("valid_out high in the cycles right after reset");
			fail_count++;
		end

	a_valid_follows: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> ##LATENCY valid_out)
		else begin
			$error("valid_out missing after an accepted pair");
			fail_count++;
		end

	a_idle_follows: assert property (@(posedge clk) disable iff (rst)
		!in_valid |-> ##LATENCY !valid_out)
		else begin
			$error("valid_out high without a matching in_valid");
			fail_count++;
		end

	a_invalid_nan: assert property (@(posedge clk) disable iff (rst)
		in_valid && invalid_in |-> ##LATENCY (z == fp_mult_pkg::QNAN))
		else begin
			$error("invalid operation did not give the quiet nan");
			fail_count++;
		end

	a_signed_inf: assert property (@(posedge clk) disable iff (rst)
		in_valid && inf_in |->
		##LATENCY (z == {$past(sign_in, LATENCY), 11'h7ff, 52'h0}))
		else begin
			$error("infinite operand did not give a signed infinity");
			fail_count++;
		end

	a_signed_zero: assert property (@(posedge clk) disable iff (rst)
		in_valid && zero_in |->
		##LATENCY (z == {$past(sign_in, LATENCY), 63'h0}))
		else begin
			$error("zero operand did not give a signed zero");
			fail_count++;
		end

endmodule

bind fp_mult fp_mult_sva #(
	.MULT_STAGES (MULT_STAGES)
) sva_inst (
	.clk       (clk),
	.rst       (rst),
	.a         (a),
	.b         (b),
	.in_valid  (in_valid),
	.z         (z),
	.valid_out (valid_out)
);

`default_nettype wire

// ==== verification/fp_mult_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_mult_tb;

	localparam int NUM_RANDOM    = 400;
	localparam int DRAIN_TIMEOUT = 100;

	logic                clk;
	logic                rst;
	fp_mult_pkg::word_t  a;
	fp_mult_pkg::word_t  b;
	logic                in_valid;
	fp_mult_pkg::word_t  z;
	logic                valid_out;

	integer              seed;
	fp_mult_pkg::word_t  expected_q [$];
	fp_mult_pkg::word_t  expected;

	fp_mult #(
		.MULT_STAGES (fp_mult_pkg::DEFAULT_MULT_STAGES)
	) fp_mult_inst (
		.clk       (clk),
		.rst       (rst),
		.a         (a),
		.b         (b),
		.in_valid  (in_valid),
		.z         (z),
		.valid_out (valid_out)
	);

	initial clk = 1'b0;

	always #10 clk = ~clk;

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	// a subnormal operand becomes zero of the same sign
	function automatic fp_mult_pkg::word_t flush_subnormal(input fp_mult_pkg::word_t w);
		if (w[62:52] == 11'h000)
			return {w[63], 63'h0};
		return w;
	endfunction

	function automatic fp_mult_pkg::word_t reference_product(
		input fp_mult_pkg::word_t x,
		input fp_mult_pkg::word_t y
	);
		real                 prod;
		fp_mult_pkg::word_t  bits;
		prod = $bitstoreal(flush_subnormal(x)) * $bitstoreal(flush_subnormal(y));
		bits = $realtobits(prod);
		// any nan becomes the one canonical pattern
		if (bits[62:52] == 11'h7ff && bits[51:0] != '0)
			bits = fp_mult_pkg::QNAN;
		return bits;
	endfunction

	// exponent kept within +-400 of the bias, so products stay normal
	function automatic fp_mult_pkg::word_t random_normal();
		logic         sign;
		logic [10:0]  exp_field;
		logic [63:0]  raw;
		sign      = $random(seed);
		exp_field = 11'(fp_mult_pkg::BIAS - 400 + ($unsigned($random(seed)) % 801));
		raw       = {$random(seed), $random(seed)};
		return {sign, exp_field, raw[51:0]};
	endfunction

	task automatic drive_pair(input fp_mult_pkg::word_t x, input fp_mult_pkg::word_t y);
		@(negedge clk);
		a        = x;
		b        = y;
		in_valid = 1'b1;
		expected_q.push_back(reference_product(x, y));
	endtask

	task automatic drive_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	task automatic wait_for_drain();
		int cycles;
		drive_idle(1);
		cycles = 0;
		while (expected_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (expected_q.size() != 0)
			stop_with_failure("timeout: valid_out did not return every pending result");
	endtask

	// results are compared in the middle of the cycle, where z is settled
	always @(negedge clk) begin
		if (!rst && valid_out) begin
			if (expected_q.size() == 0) begin
				stop_with_failure("valid_out rose with no operand pair outstanding");
			end else begin
				expected = expected_q.pop_front();
				assert (z === expected) else begin
					$display("[ERROR] %0t ns: z expected %h, got %h", $time, expected, z);
					stop_with_failure("result mismatch against the reference model");
				end
			end
		end
		if (fp_mult_inst.sva_inst.fail_count != 0)
			stop_with_failure("a concurrent assertion on fp_mult failed");
	end

	initial begin
		seed     = 32'heda26604;
		rst      = 1'b1;
		a        = '0;
		b        = '0;
		in_valid = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// rounding: ties to odd and even lsb, and the carry into the exponent
		drive_pair(64'h3ff8000000000000, 64'h3ff0000000000001);
		drive_pair(64'h4008000000000000, 64'h3ff0000000000001);
		drive_pair(64'h3ff8000000000000, 64'h3ff0000000000003);
		drive_pair(64'h3ff8000000000000, 64'h3ff5555555555555);
		drive_pair(64'h3ff0000000000000, 64'h3ff0000000000000);
		// overflow and flush
		drive_pair(64'h7fefffffffffffff, 64'h4000000000000000);
		drive_pair(64'hffefffffffffffff, 64'h4000000000000000);
		drive_pair(64'h1a70000000000000, 64'h9a70000000000000);
		wait_for_drain();

		// special operands, one gap in between
		drive_pair(64'h7ff8000000000001, 64'h3ff0000000000000);
		drive_pair(64'h3ff0000000000000, 64'hfff0000000000123);
		drive_pair(64'h7ff0000000000000, 64'h0000000000000000);
		drive_pair(64'h8000000000000000, 64'h7ff0000000000000);
		drive_idle(2);
		drive_pair(64'hfff0000000000000, 64'h4000000000000000);
		drive_pair(64'h0000000000000000, 64'hc008000000000000);
		drive_pair(64'h0000000000000001, 64'hc000000000000000);
		drive_pair(64'h7ff0000000000000, 64'h800fffffffffffff);
		wait_for_drain();

		for (int n = 0; n < NUM_RANDOM; n++) begin
			if (($random(seed) & 7) == 0)
				drive_idle(1 + ($unsigned($random(seed)) % 3));
			drive_pair(random_normal(), random_normal());
		end
		wait_for_drain();

		repeat (2) @(negedge clk);
		if (fp_mult_inst.sva_inst.fail_count != 0) begin
			stop_with_failure("a concurrent assertion on fp_mult failed");
		end else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire
